// ==== verilog/wb_arb_macros.svh ====
`ifndef WB_ARB_MACROS_SVH
`define WB_ARB_MACROS_SVH

// Number of masters sharing the slave port.
`define WB_NUM_MASTERS 3

// Data and address width of the bus.
`define WB_DW 16

// Mapped registers in the slave, addresses 0 to WB_REG_COUNT-1.
`define WB_REG_COUNT 16

// Wait states from the first strobe sample to ack.
`define WB_SLAVE_WAIT 2

// Silent cycles with cyc high before the bus times out.
`define WB_TIMEOUT_CYCLES 8

`endif

// ==== verilog/wb_bus_pkg.sv ====
`default_nettype none

`include "wb_arb_macros.svh"

package wb_bus_pkg;

  // One master request on the classic Wishbone interface.
  // adr, dat and we must stay stable while cyc and stb are high.
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [`WB_DW-1:0] adr;
    logic [`WB_DW-1:0] dat;
  } wb_req_t;

  // Response returned to one master.
  // dat is shared by all masters, ack and err reach only the owner.
  typedef struct packed {
    logic [`WB_DW-1:0] dat;
    logic             ack;
    logic             err;
  } wb_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/wb_arb_pkg.sv ====
`default_nettype none

`include "wb_arb_macros.svh"

package wb_arb_pkg;

  // Index of a master on the arbiter.
  typedef logic [$clog2(`WB_NUM_MASTERS)-1:0] master_id_t;

  // Current grant. busy is high for the whole slave cycle.
  typedef struct packed {
    logic       busy;
    master_id_t owner;
  } grant_t;

endpackage

`default_nettype wire

// ==== verilog/wbm_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_arb_macros.svh"

module wbm_arbiter #(
  parameter int NUM_MASTERS = `WB_NUM_MASTERS
) (
  input  wire                                    wb_clk_i,
  input  wire                                    wb_rst_i,
  input  wb_bus_pkg::wb_req_t [NUM_MASTERS-1:0] wbm_req_i,
  input  wire                [NUM_MASTERS-1:0] wbm_mask_i,
  output wb_bus_pkg::wb_rsp_t [NUM_MASTERS-1:0] wbm_rsp_o,
  output wb_bus_pkg::wb_req_t                   wbs_req_o,
  input  wire                [`WB_DW-1:0]      wbs_dat_i,
  input  wire                                    wbs_ack_i,
  input  wire                                    timeout_i,
  output wb_arb_pkg::master_id_t                wbm_id_o
);

  import wb_arb_pkg::*;

  logic [NUM_MASTERS-1:0] pending_q;
  grant_t                 grant_q;
  master_id_t             next_owner;
  logic                   bus_done;

  // The slave cycle ends on ack or on a watchdog timeout.
  assign bus_done = grant_q.busy & (wbs_ack_i | timeout_i);

  // Highest-index pending master wins.
  always_comb begin
    next_owner = grant_q.owner;
    for (int j = 0; j < NUM_MASTERS; j++) begin
      if (pending_q[j]) begin
        next_owner = master_id_t'(j);
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      pending_q     <= '0;
      grant_q.busy  <= 1'b0;
      grant_q.owner <= master_id_t'(NUM_MASTERS - 1);
    end else begin
      for (int i = 0; i < NUM_MASTERS; i++) begin
        if (wbm_req_i[i].cyc && wbm_req_i[i].stb && wbm_mask_i[i]) begin
          pending_q[i] <= 1'b1;
        end
      end

      // Clearing comes after capture so the owner's held request
      // does not re-arm its pending bit on the closing edge.
      if (bus_done) begin
        pending_q[grant_q.owner] <= 1'b0;
        grant_q.busy             <= 1'b0;
      end else if (!grant_q.busy) begin
        grant_q.owner <= next_owner;
        if (|pending_q) begin
          grant_q.busy <= 1'b1;
        end
      end
    end
  end

  // cyc and stb stay up for the whole grant.
  always_comb begin
    wbs_req_o.cyc = grant_q.busy;
    wbs_req_o.stb = grant_q.busy;
    wbs_req_o.we  = wbm_req_i[grant_q.owner].we;
    wbs_req_o.adr = wbm_req_i[grant_q.owner].adr;
    wbs_req_o.dat = wbm_req_i[grant_q.owner].dat;
  end

  // Read data goes to every master, ack and err to the owner only.
  always_comb begin
    for (int k = 0; k < NUM_MASTERS; k++) begin
      wbm_rsp_o[k].dat = wbs_dat_i;
      wbm_rsp_o[k].ack = (grant_q.owner == master_id_t'(k)) & wbs_ack_i;
      wbm_rsp_o[k].err = (grant_q.owner == master_id_t'(k)) & timeout_i & ~wbs_ack_i;
    end
  end

  assign wbm_id_o = grant_q.owner;

endmodule

`default_nettype wire

// ==== verilog/wb_timeout_watchdog.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_arb_macros.svh"

module wb_timeout_watchdog (
  input  wire  wb_clk_i,
  input  wire  wb_rst_i,
  input  wire  cyc_i,
  input  wire  ack_i,
  output logic timeout_o
);

  localparam int CNT_W = $clog2(`WB_TIMEOUT_CYCLES);

  logic [CNT_W-1:0] silent_cnt;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      silent_cnt <= '0;
      timeout_o  <= 1'b0;
    end else begin
      timeout_o <= 1'b0;
      // Holding the count at zero during the pulse keeps it to one cycle.
      if (!cyc_i || ack_i || timeout_o) begin
        silent_cnt <= '0;
      end else if (silent_cnt == CNT_W'(`WB_TIMEOUT_CYCLES - 1)) begin
        silent_cnt <= '0;
        timeout_o  <= 1'b1;
      end else begin
        silent_cnt <= silent_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wb_slave_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_arb_macros.svh"

module wb_slave_regs (
  input  wire                      wb_clk_i,
  input  wire                      wb_rst_i,
  input  wb_bus_pkg::wb_req_t      wbs_req_i,
  output logic [`WB_DW-1:0]        wbs_dat_o,
  output logic                     wbs_ack_o
);

  localparam int CNT_W = $clog2(`WB_SLAVE_WAIT + 1);
  localparam int IDX_W = $clog2(`WB_REG_COUNT);

  logic [`WB_DW-1:0] regs [`WB_REG_COUNT];
  logic [CNT_W-1:0]  wait_cnt;
  logic [IDX_W-1:0]  reg_idx;
  logic              mapped;
  logic              access;
  logic              last_wait;

  assign reg_idx = wbs_req_i.adr[IDX_W-1:0];

  // Unmapped addresses never start the wait counter, so they never ack.
  assign mapped = wbs_req_i.adr < `WB_DW'(`WB_REG_COUNT);

  assign access    = wbs_req_i.cyc & wbs_req_i.stb & mapped & ~wbs_ack_o;
  assign last_wait = wait_cnt == CNT_W'(`WB_SLAVE_WAIT - 1);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wbs_ack_o <= 1'b0;
      wait_cnt  <= '0;
      for (int i = 0; i < `WB_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      wbs_ack_o <= 1'b0;
      if (access) begin
        if (last_wait) begin
          wbs_ack_o <= 1'b1;
          wait_cnt  <= '0;
          // Write lands on the edge that raises ack.
          if (wbs_req_i.we) begin
            regs[reg_idx] <= wbs_req_i.dat;
          end
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
      end else begin
        wait_cnt <= '0;
      end
    end
  end

  // Read data is only valid alongside ack.
  assign wbs_dat_o = wbs_ack_o ? regs[reg_idx] : '0;

endmodule

`default_nettype wire

// ==== verilog/wb_arb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_arb_macros.svh"

module wb_arb_top (
  input  wire                                        wb_clk_i,
  input  wire                                        wb_rst_i,
  input  wb_bus_pkg::wb_req_t [`WB_NUM_MASTERS-1:0] wbm_req_i,
  input  wire                [`WB_NUM_MASTERS-1:0] wbm_mask_i,
  output wb_bus_pkg::wb_rsp_t [`WB_NUM_MASTERS-1:0] wbm_rsp_o,
  output wb_arb_pkg::master_id_t                    wbm_id_o
);

  import wb_bus_pkg::*;

  wb_req_t           bus_req;
  logic [`WB_DW-1:0] bus_dat;
  logic              bus_ack;
  logic              bus_timeout;

  wbm_arbiter #(
    .NUM_MASTERS(`WB_NUM_MASTERS)
  ) u_arbiter (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbm_req_i (wbm_req_i),
    .wbm_mask_i(wbm_mask_i),
    .wbm_rsp_o (wbm_rsp_o),
    .wbs_req_o (bus_req),
    .wbs_dat_i (bus_dat),
    .wbs_ack_i (bus_ack),
    .timeout_i (bus_timeout),
    .wbm_id_o  (wbm_id_o)
  );

  wb_timeout_watchdog u_watchdog (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .cyc_i    (bus_req.cyc),
    .ack_i    (bus_ack),
    .timeout_o(bus_timeout)
  );

  wb_slave_regs u_slave (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wbs_req_i(bus_req),
    .wbs_dat_o(bus_dat),
    .wbs_ack_o(bus_ack)
  );

endmodule

`default_nettype wire

// ==== test/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic wb_clk_o,
  output logic wb_rst_o
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 8;

  initial begin
    wb_clk_o = 1'b0;
    forever #HALF_PERIOD wb_clk_o = ~wb_clk_o;
  end

  // Reset drops just after a rising edge, like every other input.
  initial begin
    wb_rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge wb_clk_o);
    #1;
    wb_rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== test/wb_arb_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_arb_macros.svh"

module wb_arb_sva #(
  parameter int NUM_MASTERS = `WB_NUM_MASTERS
) (
  input wire                                     wb_clk_i,
  input wire                                     wb_rst_i,
  input wb_bus_pkg::wb_rsp_t [NUM_MASTERS-1:0]  wbm_rsp_i,
  input wb_bus_pkg::wb_req_t                    wbs_req_i,
  input wb_arb_pkg::master_id_t                 wbm_id_i
);

  logic [NUM_MASTERS-1:0] acks;
  logic [NUM_MASTERS-1:0] errs;
  int unsigned            error_count = 0;

  always_comb begin
    for (int k = 0; k < NUM_MASTERS; k++) begin
      acks[k] = wbm_rsp_i[k].ack;
      errs[k] = wbm_rsp_i[k].err;
    end
  end

  // Ack and err each reach at most one master.
  one_response_a: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0(acks) && $onehot0(errs))
    else begin
      error_count++;
      $error("More than one ack or err in the same cycle");
    end

  // A bus cycle ends either by ack or by err.
  no_ack_with_err_a: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(|acks && |errs))
    else begin
      error_count++;
      $error("Ack and err were high together");
    end

  // The owner may only change while the slave port is idle.
  owner_stable_a: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wbs_req_i.cyc && $past(wbs_req_i.cyc)) |-> $stable(wbm_id_i))
    else begin
      error_count++;
      $error("Owner id changed during an open bus cycle");
    end

endmodule

bind wbm_arbiter wb_arb_sva #(
  .NUM_MASTERS(NUM_MASTERS)
) u_arb_sva (
  .wb_clk_i (wb_clk_i),
  .wb_rst_i (wb_rst_i),
  .wbm_rsp_i(wbm_rsp_o),
  .wbs_req_i(wbs_req_o),
  .wbm_id_i (wbm_id_o)
);

`default_nettype wire

// ==== test/wb_arb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_arb_macros.svh"

module wb_arb_tb;

  import wb_bus_pkg::*;
  import wb_arb_pkg::*;

  localparam int NUM_M     = `WB_NUM_MASTERS;
  localparam int REG_COUNT = `WB_REG_COUNT;
  // Worst single access is a timeout behind two other masters, with margin.
  localparam int ACCESS_LIMIT = 40;
  // At most 70 accesses at that bound, plus reset and the mask window.
  localparam int CYCLE_LIMIT = 70 * ACCESS_LIMIT + 200;

  logic                wb_clk;
  logic                wb_rst;
  wb_req_t [NUM_M-1:0] wbm_req;
  logic    [NUM_M-1:0] wbm_mask;
  wb_rsp_t [NUM_M-1:0] wbm_rsp;
  master_id_t          wbm_id;

  logic [`WB_DW-1:0] model [REG_COUNT];
  int                ack_order [$];
  int                cycle_count = 0;
  integer            seed;

  tb_clkgen u_clkgen (
    .wb_clk_o(wb_clk),
    .wb_rst_o(wb_rst)
  );

  wb_arb_top uut (
    .wb_clk_i  (wb_clk),
    .wb_rst_i  (wb_rst),
    .wbm_req_i (wbm_req),
    .wbm_mask_i(wbm_mask),
    .wbm_rsp_o (wbm_rsp),
    .wbm_id_o  (wbm_id)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic start_request(input int m, input logic we, input logic [15:0] adr,
                               input logic [15:0] dat);
    wbm_req[m].cyc = 1'b1;
    wbm_req[m].stb = 1'b1;
    wbm_req[m].we  = we;
    wbm_req[m].adr = adr;
    wbm_req[m].dat = dat;
  endtask

  // Waits for ack or err, samples mid-cycle, then drops the request.
  task automatic wait_response(input int m, output logic [15:0] rdata, output logic err,
                               output master_id_t id);
    int waited = 0;
    do begin
      @(negedge wb_clk);
      waited++;
      if (waited > ACCESS_LIMIT) begin
        abort_run($sformatf("Master %0d saw no ack or err within %0d cycles",
                            m, ACCESS_LIMIT));
      end
    end while (!(wbm_rsp[m].ack || wbm_rsp[m].err));
    rdata = wbm_rsp[m].dat;
    err   = wbm_rsp[m].err;
    id    = wbm_id;
    if (wbm_rsp[m].ack) begin
      ack_order.push_back(m);
    end
    for (int k = 0; k < NUM_M; k++) begin
      if (k != m) begin
        check_value($sformatf("wbm_rsp[%0d].ack", k), 16'(wbm_rsp[k].ack), 16'h0);
        check_value($sformatf("wbm_rsp[%0d].err", k), 16'(wbm_rsp[k].err), 16'h0);
      end
    end
    @(posedge wb_clk);
    #1;
    wbm_req[m] = '0;
  endtask

  task automatic write_reg(input int m, input logic [15:0] adr, input logic [15:0] dat);
    logic [15:0] rdata;
    logic        err;
    master_id_t  id;
    start_request(m, 1'b1, adr, dat);
    wait_response(m, rdata, err, id);
    check_value($sformatf("wbm_rsp[%0d].err", m), 16'(err), 16'h0);
    check_value("wbm_id_o", 16'(id), 16'(m));
    model[int'(adr)] = dat;
  endtask

  task automatic read_reg(input int m, input logic [15:0] adr);
    logic [15:0] rdata;
    logic        err;
    master_id_t  id;
    start_request(m, 1'b0, adr, 16'h0);
    wait_response(m, rdata, err, id);
    check_value($sformatf("wbm_rsp[%0d].err", m), 16'(err), 16'h0);
    check_value("wbm_id_o", 16'(id), 16'(m));
    check_value($sformatf("wbm_rsp[%0d].dat", m), rdata, model[int'(adr)]);
  endtask

  task automatic test_single_master();
    write_reg(0, 16'h0001, 16'h1234);
    read_reg(0, 16'h0001);
  endtask

  task automatic test_every_master();
    for (int m = 0; m < NUM_M; m++) begin
      write_reg(m, 16'(4 + m), 16'hA5A0 + 16'(m));
    end
    // Reader (r+1)%3 never matches the writer of registers 4 to 6.
    for (int r = 0; r < REG_COUNT; r++) begin
      read_reg((r + 1) % NUM_M, 16'(r));
    end
  endtask

  task automatic test_priority();
    ack_order.delete();
    fork
      write_reg(0, 16'h0009, 16'h0900);
      write_reg(1, 16'h000A, 16'h0A00);
      write_reg(2, 16'h000B, 16'h0B00);
    join
    check_value("ack count", 16'(ack_order.size()), 16'(NUM_M));
    for (int i = 0; i < NUM_M; i++) begin
      check_value($sformatf("ack order[%0d]", i), 16'(ack_order[i]), 16'(NUM_M - 1 - i));
    end
    for (int r = 9; r < 12; r++) begin
      read_reg(0, 16'(r));
    end
  endtask

  task automatic test_mask();
    logic [15:0] rdata;
    logic        err;
    master_id_t  id;
    write_reg(1, 16'h0007, 16'h7777);
    wbm_mask    = '1;
    wbm_mask[0] = 1'b0;
    start_request(0, 1'b0, 16'h0007, 16'h0);
    fork
      begin
        repeat (20) begin
          @(negedge wb_clk);
          check_value("wbm_rsp[0].ack", 16'(wbm_rsp[0].ack), 16'h0);
          check_value("wbm_rsp[0].err", 16'(wbm_rsp[0].err), 16'h0);
        end
      end
      begin
        write_reg(1, 16'h0008, 16'h8888);
        read_reg(2, 16'h0008);
      end
    join
    @(posedge wb_clk);
    #1;
    wbm_mask = '1;
    wait_response(0, rdata, err, id);
    check_value("wbm_rsp[0].err", 16'(err), 16'h0);
    check_value("wbm_id_o", 16'(id), 16'h0);
    check_value("wbm_rsp[0].dat", rdata, model[7]);
  endtask

  task automatic test_unmapped();
    logic [15:0] rdata;
    logic        err;
    master_id_t  id;
    start_request(1, 1'b0, 16'd40, 16'h0);
    wait_response(1, rdata, err, id);
    check_value("wbm_rsp[1].err", 16'(err), 16'h1);
    check_value("wbm_id_o", 16'(id), 16'h1);
    // No ack means the slave drives no data.
    check_value("wbm_rsp[1].dat", rdata, 16'h0);
    write_reg(1, 16'h0003, 16'h3C3C);
    read_reg(0, 16'h0003);
  endtask

  task automatic test_random_traffic();
    logic [31:0] r;
    int          m;
    logic [15:0] adr;
    repeat (20) begin
      r   = $random(seed);
      m   = int'(r[7:0]) % NUM_M;
      adr = 16'(r[11:8]);
      if (r[12]) begin
        write_reg(m, adr, r[31:16]);
      end else begin
        read_reg(m, adr);
      end
    end
  endtask

  always @(posedge wb_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      abort_run($sformatf("Run did not finish within %0d clock cycles", CYCLE_LIMIT));
    end
    if (uut.u_arbiter.u_arb_sva.error_count != 0) begin
      abort_run("An arbiter assertion failed");
    end
  end

  initial begin
    seed     = 31;
    wbm_req  = '0;
    wbm_mask = '1;
    for (int i = 0; i < REG_COUNT; i++) begin
      model[i] = '0;
    end
    @(negedge wb_rst);
    @(posedge wb_clk);
    #1;
    test_single_master();
    test_every_master();
    test_priority();
    test_mask();
    test_unmapped();
    test_random_traffic();
    @(posedge wb_clk);
    #1;
    if (uut.u_arbiter.u_arb_sva.error_count != 0) begin
      abort_run("An arbiter assertion failed");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
verilog/wb_bus_pkg.sv
verilog/wb_arb_pkg.sv
verilog/wbm_arbiter.sv
verilog/wb_timeout_watchdog.sv
verilog/wb_slave_regs.sv
verilog/wb_arb_top.sv
test/tb_clkgen.sv
test/wb_arb_sva.sv
test/wb_arb_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then search the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module wb_arb_tb -f project.f -o wb_arb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/wb_arb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
  echo "Result: passed"
  exit 0
fi
echo "Result: failed"
exit 1
